// File: sim/sb_testdata.txt
# hex fields: I fu rd | U fu rd | W port tid data ex | C rd result ex | K reg fu | S full | F
# R rs1 rs2 data1 valid1 data2 valid2; W lines act together with the next command
S 0
I 1 5
I 3 6
I 0 0
K 0 0
K 5 1
K 6 3
W 0 0 1234 0
W 1 1 dead 0
R 5 6 1234 1 dead 1
C 5 1234 0
C 6 dead 0
C 0 0 0
K 5 0
I 1 7
I 5 7
W 1 4 bbbb 0
K 7 1
W 0 3 1111 0
W 1 4 2222 0
R 7 0 1111 1 0 0
W 0 3 cccc 1
R 7 7 1111 1 1111 1
C 7 cccc 1
K 7 5
C 7 2222 0
K 7 0
I 1 1
I 2 2
I 3 3
I 4 4
I 5 8
I 0 9
I 1 a
I 3 b
S 1
W 0 5 abcd 0
C 1 abcd 0
S 0
F
S 0
K 2 0
R 9 a 0 0 0 0
U 1 c
K c 0
I 1 d
W 0 0 5555 0
C d 5555 0

// File: verilog.f
common/sb_cfg_pkg.sv
common/sb_instr_pkg.sv
src/prio_select.sv
scoreboard/sb_queue.sv
scoreboard/sb_clobber.sv
scoreboard/sb_operand_fwd.sv
scoreboard/sb_top.sv
sim/tb_sb.sv

// File: run_sim.sh
#!/bin/sh
# compile the scoreboard testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f verilog.f --top-module tb_sb -o tb_sb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: sim/tb_sb.sv
`timescale 1ns/1ps

module tb_sb import sb_cfg_pkg::*, sb_instr_pkg::*;;

  localparam int MAX_WAIT_CYCLES = 40;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        flush_i;
  logic                        flush_unissued_i;
  logic                        unresolved_branch_i;
  sb_entry_t                   decoded_instr_i;
  logic                        decoded_instr_valid_i;
  logic                        decoded_instr_ack_o;
  sb_entry_t                   issue_instr_o;
  logic                        issue_instr_valid_o;
  logic                        issue_ack_i;
  logic                        sb_full_o;
  logic      [NR_WB_PORTS-1:0] wb_valid_i;
  trans_id_t [NR_WB_PORTS-1:0] wb_trans_id_i;
  xlen_t     [NR_WB_PORTS-1:0] wb_data_i;
  logic      [NR_WB_PORTS-1:0] wb_ex_i;
  sb_entry_t                   commit_instr_o;
  logic                        commit_ack_i;
  fu_t       [NR_REGS-1:0]     rd_clobber_o;
  reg_addr_t                   rs1_i;
  reg_addr_t                   rs2_i;
  xlen_t                       rs1_o;
  xlen_t                       rs2_o;
  logic                        rs1_valid_o;
  logic                        rs2_valid_o;

  // bookkeeping
  int checks;
  int mismatches;
  int timeouts;
  int other_errors;
  bit aborted;

  // expected ring pointers wrap at the ring size like the slots do
  trans_id_t issue_ptr;
  trans_id_t commit_ptr;

  // write-backs collected from W lines go out with the next command
  logic      [NR_WB_PORTS-1:0] stage_valid;
  trans_id_t [NR_WB_PORTS-1:0] stage_tid;
  xlen_t     [NR_WB_PORTS-1:0] stage_data;
  logic      [NR_WB_PORTS-1:0] stage_ex;

  sb_top DUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .sb_full_o             (sb_full_o),
    .wb_valid_i            (wb_valid_i),
    .wb_trans_id_i         (wb_trans_id_i),
    .wb_data_i             (wb_data_i),
    .wb_ex_i               (wb_ex_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .rd_clobber_o          (rd_clobber_o),
    .rs1_i                 (rs1_i),
    .rs2_i                 (rs2_i),
    .rs1_o                 (rs1_o),
    .rs2_o                 (rs2_o),
    .rs1_valid_o           (rs1_valid_o),
    .rs2_valid_o           (rs2_valid_o)
  );

  // 10 ns clock
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // staged write-backs go out for exactly one cycle from this rising edge
  task automatic start_cycle();
    @(posedge clk_i);
    wb_valid_i    <= stage_valid;
    wb_trans_id_i <= stage_tid;
    wb_data_i     <= stage_data;
    wb_ex_i       <= stage_ex;
    stage_valid   = '0;
  endtask

  // ports fall idle at the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    wb_valid_i <= '0;
  endtask

  task automatic report_bad_line(input string cmd);
    $display("test data line with command %s is unknown or malformed", cmd);
    other_errors++;
    aborted = 1'b1;
  endtask

  // no register may have a pending writer
  task automatic clobbers_idle(input string when);
    for (int r = 0; r < NR_REGS; r++) begin
      check_val($sformatf("clobber of x%0d %s", r, when), 32'(rd_clobber_o[r]), 32'(NONE));
    end
  endtask

  // ---------------------------------------------------------------------
  // commands
  // ---------------------------------------------------------------------

  task automatic issue_instr(input logic [31:0] fu, input logic [31:0] rd, input bit unissued);
    sb_entry_t instr;
    int        waited;
    instr    = '0;
    instr.fu = fu_t'(fu[2:0]);
    instr.rd = rd[REG_ADDR_BITS-1:0];
    start_cycle();
    decoded_instr_i       <= instr;
    decoded_instr_valid_i <= 1'b1;
    issue_ack_i           <= 1'b1;
    flush_unissued_i      <= unissued;
    waited = 0;
    @(negedge clk_i);
    // under flush_unissued the attempt lasts one cycle and leaves no entry
    while (!unissued && !(issue_instr_valid_o && decoded_instr_ack_o) &&
           waited < MAX_WAIT_CYCLES) begin
      waited++;
      next_cycle();
      @(negedge clk_i);
    end
    if (unissued) begin
      check_val("ack under flush_unissued", 32'(decoded_instr_ack_o), 32'd1);
    end else if (issue_instr_valid_o && decoded_instr_ack_o) begin
      check_val("issue trans_id", 32'(issue_instr_o.trans_id), 32'(issue_ptr));
      issue_ptr++;
    end else begin
      $display("timeout: the issue handshake never completed");
      timeouts++;
      aborted = 1'b1;
    end
    next_cycle();
    decoded_instr_valid_i <= 1'b0;
    issue_ack_i           <= 1'b0;
    flush_unissued_i      <= 1'b0;
  endtask

  task automatic commit_oldest(input logic [31:0] rd, input logic [31:0] res,
                               input logic [31:0] ex);
    int waited;
    start_cycle();
    waited = 0;
    @(negedge clk_i);
    while (!commit_instr_o.valid && waited < MAX_WAIT_CYCLES) begin
      waited++;
      next_cycle();
      @(negedge clk_i);
    end
    if (commit_instr_o.valid) begin
      check_val("commit rd", 32'(commit_instr_o.rd), rd);
      check_val("commit result", commit_instr_o.result, res);
      check_val("commit ex_valid", 32'(commit_instr_o.ex_valid), ex);
      check_val("commit trans_id", 32'(commit_instr_o.trans_id), 32'(commit_ptr));
      next_cycle();
      commit_ack_i <= 1'b1;
      next_cycle();
      commit_ack_i <= 1'b0;
      commit_ptr++;
    end else begin
      $display("timeout: no committable entry showed up");
      timeouts++;
      aborted = 1'b1;
    end
  endtask

  task automatic read_operands(input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] val_a, input logic [31:0] ok_a,
                               input logic [31:0] val_b, input logic [31:0] ok_b);
    start_cycle();
    rs1_i <= a[REG_ADDR_BITS-1:0];
    rs2_i <= b[REG_ADDR_BITS-1:0];
    @(negedge clk_i);
    check_val("rs1 valid", 32'(rs1_valid_o), ok_a);
    check_val("rs2 valid", 32'(rs2_valid_o), ok_b);
    // data only matters where a hit is expected
    if (ok_a != 0) begin
      check_val("rs1 data", rs1_o, val_a);
    end
    if (ok_b != 0) begin
      check_val("rs2 data", rs2_o, val_b);
    end
  endtask

  task automatic clobber_probe(input logic [31:0] rd, input logic [31:0] fu);
    start_cycle();
    @(negedge clk_i);
    check_val("clobber fu", 32'(rd_clobber_o[rd[REG_ADDR_BITS-1:0]]), fu);
  endtask

  // ack offered without a valid instruction so nothing gets written
  task automatic full_probe(input logic [31:0] exp_full);
    start_cycle();
    issue_ack_i <= 1'b1;
    @(negedge clk_i);
    check_val("sb_full", 32'(sb_full_o), exp_full);
    check_val("decoded ack", 32'(decoded_instr_ack_o), 32'(exp_full == 0));
    next_cycle();
    issue_ack_i <= 1'b0;
  endtask

  task automatic flush_ring();
    start_cycle();
    flush_i <= 1'b1;
    next_cycle();
    flush_i    <= 1'b0;
    issue_ptr  = '0;
    commit_ptr = '0;
    @(negedge clk_i);
    clobbers_idle("after flush");
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------

  initial begin
    int          fd;
    int          ch;
    int          port;
    string       cmd;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    checks                = 0;
    mismatches            = 0;
    timeouts              = 0;
    other_errors          = 0;
    aborted               = 1'b0;
    issue_ptr             = '0;
    commit_ptr            = '0;
    stage_valid           = '0;
    stage_tid             = '0;
    stage_data            = '0;
    stage_ex              = '0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    flush_unissued_i      = 1'b0;
    unresolved_branch_i   = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    wb_valid_i            = '0;
    wb_trans_id_i         = '0;
    wb_data_i             = '0;
    wb_ex_i               = '0;
    commit_ack_i          = 1'b0;
    rs1_i                 = '0;
    rs2_i                 = '0;

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("full after reset", 32'(sb_full_o), 32'd0);
    check_val("issue valid after reset", 32'(issue_instr_valid_o), 32'd0);
    check_val("commit valid after reset", 32'(commit_instr_o.valid), 32'd0);
    clobbers_idle("after reset");

    fd = $fopen("sim/sb_testdata.txt", "r");
    if (fd == 0) begin
      $display("the test data file could not be opened");
      other_errors++;
    end else begin
      while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
          // skip the rest of a comment line
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if (cmd == "I" || cmd == "U") begin
          if ($fscanf(fd, "%h %h", f0, f1) == 2) begin
            issue_instr(f0, f1, cmd == "U");
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "W") begin
          if ($fscanf(fd, "%h %h %h %h", f0, f1, f2, f3) == 4 && f0 < NR_WB_PORTS) begin
            port              = int'(f0);
            stage_valid[port] = 1'b1;
            stage_tid[port]   = f1[TRANS_ID_BITS-1:0];
            stage_data[port]  = f2;
            stage_ex[port]    = f3[0];
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "C") begin
          if ($fscanf(fd, "%h %h %h", f0, f1, f2) == 3) begin
            commit_oldest(f0, f1, f2);
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "R") begin
          if ($fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5) == 6) begin
            read_operands(f0, f1, f2, f3, f4, f5);
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "K") begin
          if ($fscanf(fd, "%h %h", f0, f1) == 2) begin
            clobber_probe(f0, f1);
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "S") begin
          if ($fscanf(fd, "%h", f0) == 1) begin
            full_probe(f0);
          end else begin
            report_bad_line(cmd);
          end
        end else if (cmd == "F") begin
          flush_ring();
        end else begin
          report_bad_line(cmd);
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk_i);
    $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
             checks, mismatches, timeouts, other_errors);
    if (mismatches + timeouts + other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: scoreboard/sb_top.sv
`timescale 1ns/1ps

module sb_top import sb_cfg_pkg::*, sb_instr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         flush_unissued_i,
  input  logic                         unresolved_branch_i,
  // decode and issue
  input  sb_entry_t                    decoded_instr_i,
  input  logic                         decoded_instr_valid_i,
  output logic                         decoded_instr_ack_o,
  output sb_entry_t                    issue_instr_o,
  output logic                         issue_instr_valid_o,
  input  logic                         issue_ack_i,
  output logic                         sb_full_o,
  // write-back
  input  logic      [NR_WB_PORTS-1:0]  wb_valid_i,
  input  trans_id_t [NR_WB_PORTS-1:0]  wb_trans_id_i,
  input  xlen_t     [NR_WB_PORTS-1:0]  wb_data_i,
  input  logic      [NR_WB_PORTS-1:0]  wb_ex_i,
  // commit
  output sb_entry_t                    commit_instr_o,
  input  logic                         commit_ack_i,
  // clobber table
  output fu_t       [NR_REGS-1:0]      rd_clobber_o,
  // operand read
  input  reg_addr_t                    rs1_i,
  input  reg_addr_t                    rs2_i,
  output xlen_t                        rs1_o,
  output xlen_t                        rs2_o,
  output logic                         rs1_valid_o,
  output logic                         rs2_valid_o
);

  sb_entry_t [NR_ENTRIES-1:0]  entries;
  logic      [NR_ENTRIES-1:0]  issued;
  reg_addr_t [NR_WB_PORTS-1:0] wb_rd;

  // entry ring with all handshakes
  sb_queue i_queue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .wb_valid_i            (wb_valid_i),
    .wb_trans_id_i         (wb_trans_id_i),
    .wb_data_i             (wb_data_i),
    .wb_ex_i               (wb_ex_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .sb_full_o             (sb_full_o),
    .entries_o             (entries),
    .issued_o              (issued),
    .wb_rd_o               (wb_rd)
  );

  // which unit will write each gpr
  sb_clobber i_clobber (
    .entries_i    (entries),
    .issued_i     (issued),
    .rd_clobber_o (rd_clobber_o)
  );

  // rs1/rs2 bypass from ports and finished entries
  sb_operand_fwd i_operand_fwd (
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .wb_valid_i  (wb_valid_i),
    .wb_ex_i     (wb_ex_i),
    .wb_data_i   (wb_data_i),
    .wb_rd_i     (wb_rd),
    .entries_i   (entries),
    .issued_i    (issued),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

// File: scoreboard/sb_operand_fwd.sv
`timescale 1ns/1ps

module sb_operand_fwd import sb_cfg_pkg::*, sb_instr_pkg::*; (
  input  reg_addr_t                   rs1_i,
  input  reg_addr_t                   rs2_i,
  input  logic      [NR_WB_PORTS-1:0] wb_valid_i,
  input  logic      [NR_WB_PORTS-1:0] wb_ex_i,
  input  xlen_t     [NR_WB_PORTS-1:0] wb_data_i,
  input  reg_addr_t [NR_WB_PORTS-1:0] wb_rd_i,
  input  sb_entry_t [NR_ENTRIES-1:0]  entries_i,
  input  logic      [NR_ENTRIES-1:0]  issued_i,
  output xlen_t                       rs1_o,
  output xlen_t                       rs2_o,
  output logic                        rs1_valid_o,
  output logic                        rs2_valid_o
);

  localparam int unsigned NR_CAND = NR_WB_PORTS + NR_ENTRIES;

  // candidates: write-back ports first, then ring slots
  logic  [NR_CAND-1:0] rs1_req, rs2_req;
  xlen_t [NR_CAND-1:0] cand_data;
  logic                rs1_hit, rs2_hit;

  // ---------------------------------------------------------------------
  // candidate requests
  // ---------------------------------------------------------------------

  // results on the ports this cycle, faulting results are not forwarded
  for (genvar k = 0; k < NR_WB_PORTS; k++) begin : gen_wb_cand
    assign rs1_req[k]   = wb_valid_i[k] & ~wb_ex_i[k] & (wb_rd_i[k] == rs1_i);
    assign rs2_req[k]   = wb_valid_i[k] & ~wb_ex_i[k] & (wb_rd_i[k] == rs2_i);
    assign cand_data[k] = wb_data_i[k];
  end

  // finished entries still waiting for commit
  for (genvar i = 0; i < NR_ENTRIES; i++) begin : gen_entry_cand
    assign rs1_req[NR_WB_PORTS+i] = issued_i[i] & entries_i[i].valid &
                                    (entries_i[i].rd == rs1_i);
    assign rs2_req[NR_WB_PORTS+i] = issued_i[i] & entries_i[i].valid &
                                    (entries_i[i].rd == rs2_i);
    assign cand_data[NR_WB_PORTS+i] = entries_i[i].result;
  end

  // ---------------------------------------------------------------------
  // selection
  // ---------------------------------------------------------------------

  prio_select #(
    .NUM_IN    (NR_CAND),
    .payload_t (xlen_t)
  ) i_sel_rs1 (
    .req_i   (rs1_req),
    .data_i  (cand_data),
    .valid_o (rs1_hit),
    .data_o  (rs1_o)
  );

  prio_select #(
    .NUM_IN    (NR_CAND),
    .payload_t (xlen_t)
  ) i_sel_rs2 (
    .req_i   (rs2_req),
    .data_i  (cand_data),
    .valid_o (rs2_hit),
    .data_o  (rs2_o)
  );

  // x0 is read from the register file, never forwarded
  assign rs1_valid_o = rs1_hit & (|rs1_i);
  assign rs2_valid_o = rs2_hit & (|rs2_i);

endmodule

// File: scoreboard/sb_clobber.sv
`timescale 1ns/1ps

module sb_clobber import sb_cfg_pkg::*, sb_instr_pkg::*; (
  input  sb_entry_t [NR_ENTRIES-1:0] entries_i,
  input  logic      [NR_ENTRIES-1:0] issued_i,
  output fu_t       [NR_REGS-1:0]    rd_clobber_o
);

  // one candidate per slot, top one is the NONE default
  fu_t [NR_ENTRIES:0] clobber_fu;

  always_comb begin
    clobber_fu[NR_ENTRIES] = NONE;
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      clobber_fu[i] = entries_i[i].fu;
    end
  end

  for (genvar k = 0; k < NR_REGS; k++) begin : gen_reg
    logic [NR_ENTRIES:0] req;

    // issued slots writing register k
    // x0 never gets clobbered, only the default remains there
    always_comb begin
      req             = '0;
      req[NR_ENTRIES] = 1'b1;
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        req[i] = issued_i[i] && (entries_i[i].rd == reg_addr_t'(k)) && (k != 0);
      end
    end

    // lowest slot wins if several entries target the same register
    prio_select #(
      .NUM_IN    (NR_ENTRIES + 1),
      .payload_t (fu_t)
    ) i_sel_clobber (
      .req_i   (req),
      .data_i  (clobber_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[k])
    );
  end

endmodule

// File: scoreboard/sb_queue.sv
`timescale 1ns/1ps

module sb_queue import sb_cfg_pkg::*, sb_instr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         flush_unissued_i,
  input  logic                         unresolved_branch_i,
  // decode side
  input  sb_entry_t                    decoded_instr_i,
  input  logic                         decoded_instr_valid_i,
  output logic                         decoded_instr_ack_o,
  // issue side
  output sb_entry_t                    issue_instr_o,
  output logic                         issue_instr_valid_o,
  input  logic                         issue_ack_i,
  // write-back ports
  input  logic      [NR_WB_PORTS-1:0]  wb_valid_i,
  input  trans_id_t [NR_WB_PORTS-1:0]  wb_trans_id_i,
  input  xlen_t     [NR_WB_PORTS-1:0]  wb_data_i,
  input  logic      [NR_WB_PORTS-1:0]  wb_ex_i,
  // commit port
  output sb_entry_t                    commit_instr_o,
  input  logic                         commit_ack_i,
  output logic                         sb_full_o,
  // ring state for clobber table and forwarding
  output sb_entry_t [NR_ENTRIES-1:0]   entries_o,
  output logic      [NR_ENTRIES-1:0]   issued_o,
  output reg_addr_t [NR_WB_PORTS-1:0]  wb_rd_o
);

  typedef logic [TRANS_ID_BITS:0] cnt_t;

  sb_entry_t [NR_ENTRIES-1:0] entries_d, entries_q;
  logic      [NR_ENTRIES-1:0] issued_d, issued_q;
  trans_id_t                  issue_ptr_d, issue_ptr_q;
  trans_id_t                  commit_ptr_d, commit_ptr_q;
  cnt_t                       cnt_d, cnt_q;
  logic                       full;
  logic                       issue_en;

  // eight in flight sets the count msb
  assign full      = cnt_q[TRANS_ID_BITS];
  assign sb_full_o = full;

  // ---------------------------------------------------------------------
  // issue handshake
  // ---------------------------------------------------------------------

  // decoded instruction goes out stamped with the slot it will occupy
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
  end

  // hold off while a branch is unresolved or the ring has no room
  assign issue_instr_valid_o = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_instr_ack_o = issue_ack_i & ~full;

  // oldest entry straight from the ring
  assign commit_instr_o = entries_q[commit_ptr_q];

  // ---------------------------------------------------------------------
  // ring update
  // ---------------------------------------------------------------------

  always_comb begin
    entries_d = entries_q;
    issued_d  = issued_q;
    issue_en  = 1'b0;

    // new entry at the issue pointer
    if (decoded_instr_valid_i && decoded_instr_ack_o && !flush_unissued_i) begin
      issue_en                = 1'b1;
      entries_d[issue_ptr_q]  = issue_instr_o;
      issued_d[issue_ptr_q]   = 1'b1;
    end

    // no unit behind it, so the entry completes by itself
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (issued_q[i] && entries_q[i].fu == NONE) begin
        entries_d[i].valid = 1'b1;
      end
    end

    // results from the units
    // late write-backs to freed slots (e.g. after a flush) are dropped
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        entries_d[wb_trans_id_i[k]].valid    = 1'b1;
        entries_d[wb_trans_id_i[k]].result   = wb_data_i[k];
        entries_d[wb_trans_id_i[k]].ex_valid = wb_ex_i[k];
      end
    end

    // commit retires the oldest slot
    if (commit_ack_i) begin
      issued_d[commit_ptr_q]        = 1'b0;
      entries_d[commit_ptr_q].valid = 1'b0;
    end

    // whole flush wipes every slot
    if (flush_i) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        issued_d[i]           = 1'b0;
        entries_d[i].valid    = 1'b0;
        entries_d[i].ex_valid = 1'b0;
      end
    end
  end

  // pointers wrap naturally at the ring size
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + trans_id_t'(commit_ack_i);
  assign cnt_d        = flush_i ? '0 : cnt_q + cnt_t'(issue_en) - cnt_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entries_q    <= '0;
      issued_q     <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      entries_q    <= entries_d;
      issued_q     <= issued_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  // ---------------------------------------------------------------------
  // state towards clobber table and forwarding
  // ---------------------------------------------------------------------

  assign entries_o = entries_q;
  assign issued_o  = issued_q;

  // destination of whatever each port is writing this cycle
  for (genvar k = 0; k < NR_WB_PORTS; k++) begin : gen_wb_rd
    assign wb_rd_o[k] = entries_q[wb_trans_id_i[k]].rd;
  end

endmodule

// File: src/prio_select.sv
`timescale 1ns/1ps

module prio_select #(
  parameter int unsigned NUM_IN = 2,
  parameter type payload_t = logic
) (
  input  logic     [NUM_IN-1:0] req_i,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic                  valid_o,
  output payload_t              data_o
);

  // fixed priority, index 0 is the strongest requester
  // walk from the top down so the lowest hit is the last one written
  always_comb begin
    valid_o = 1'b0;
    data_o  = payload_t'(0);
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

  // nothing requesting gives zero payload and valid low

endmodule

// File: common/sb_instr_pkg.sv
package sb_instr_pkg;

  import sb_cfg_pkg::*;

  // ---------------------------------------------------------------------
  // functional units
  // ---------------------------------------------------------------------

  // NONE marks instructions that need no unit and finish on their own
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5
  } fu_t;

  // ---------------------------------------------------------------------
  // scoreboard entry
  // ---------------------------------------------------------------------

  typedef struct packed {
    // unit that produces the result
    fu_t       fu;
    // destination register
    reg_addr_t rd;
    // value written back by the unit
    xlen_t     result;
    // slot index in the ring
    trans_id_t trans_id;
    // result present, entry may commit
    logic      valid;
    // unit reported an exception
    logic      ex_valid;
  } sb_entry_t;

endpackage

// File: common/sb_cfg_pkg.sv
package sb_cfg_pkg;

  // ---------------------------------------------------------------------
  // scoreboard sizing
  // ---------------------------------------------------------------------

  // ring depth, kept a power of two so the count msb doubles as full flag
  localparam int unsigned NR_ENTRIES    = 8;
  // transaction id addresses one ring slot
  localparam int unsigned TRANS_ID_BITS = $clog2(NR_ENTRIES);

  // integer register file
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;

  // datapath width
  localparam int unsigned XLEN          = 32;

  // functional units reporting results back
  localparam int unsigned NR_WB_PORTS   = 2;

  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;

endpackage
